// ==== common/idctrl_pkg.sv ====
`default_nettype none

package idctrl_pkg;

    ////////////////////
    // Bus geometry
    ////////////////////

    // Wishbone data width
    localparam int DATA_W = 32;
    // Byte address into the block
    localparam int ADDR_W = 16;

    // Word index out of address bits 5:2
    localparam int REG_IDX_W = 4;
    localparam int REG_IDX_LSB = 2;

    ////////////////////
    // Register map
    ////////////////////

    // Read-only identification
    localparam logic [REG_IDX_W-1:0] REG_DEVICE = 4'd0;
    localparam logic [REG_IDX_W-1:0] REG_VERSION = 4'd1;
    // Interrupt status, write one to clear
    localparam logic [REG_IDX_W-1:0] REG_INT_SR = 4'd2;
    // Interrupt mask, 1 suppresses
    localparam logic [REG_IDX_W-1:0] REG_INT_MASK = 4'd3;
    // LED value, front panel LED and override bits
    localparam logic [REG_IDX_W-1:0] REG_LED = 4'd6;
    // SST select, its drive enable and oscillator enable
    localparam logic [REG_IDX_W-1:0] REG_CLKSEL = 4'd7;
    // Remaining indices are reserved and read zero

    ////////////////////
    // LED layout
    ////////////////////

    // Charlieplexed LEDs, green then red
    localparam int LED_N = 12;
    // Shared pins behind them
    localparam int LED_PINS = 4;
    // Front panel LED, not charlieplexed
    localparam int LED_FP_BIT = 12;
    // Override for LED k sits at bit k + 16
    localparam int LED_OVR_LSB = 16;

    ////////////////////
    // Bundles
    ////////////////////

    // Master side of a Wishbone access
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
    } wb_req_t;

    // Decoded write strobes, one per writable block
    typedef struct packed {
        logic              sr_we;
        logic              mask_we;
        logic              led_we;
        logic [DATA_W-1:0] dat;
    } reg_wr_t;

    // Byte address to register index
    function automatic logic [REG_IDX_W-1:0] reg_idx(input logic [ADDR_W-1:0] adr);
        return adr[REG_IDX_LSB +: REG_IDX_W];
    endfunction

endpackage

`default_nettype wire

// ==== src/idctrl_bus.sv ====
`timescale 1ns/10ps
`default_nettype none

module idctrl_bus #(
    parameter logic [idctrl_pkg::DATA_W-1:0] DEVICE_ID = "S5A7",
    parameter logic [idctrl_pkg::DATA_W-1:0] VERSION = 32'h0000_0000
) (
    input  wire                                clk_i,
    input  wire                                rst_i,
    // Wishbone slave
    input  wire idctrl_pkg::wb_req_t           wb_req_i,
    output logic                               wb_ack_o,
    output logic [idctrl_pkg::DATA_W-1:0]      wb_dat_o,
    // Strobes out to the register blocks
    output idctrl_pkg::reg_wr_t                reg_wr_o,
    // Register values back from the blocks
    input  wire [idctrl_pkg::DATA_W-1:0]       sr_val_i,
    input  wire [idctrl_pkg::DATA_W-1:0]       mask_val_i,
    input  wire [idctrl_pkg::DATA_W-1:0]       led_val_i,
    // Clock selection pins
    output logic                               sst_sel_o,
    output logic                               sst_sel_oe_o,
    output logic                               local_osc_en_o
);
    import idctrl_pkg::*;

    logic                 ack_q;
    logic                 req;
    logic                 wr_req;
    logic [REG_IDX_W-1:0] idx;
    logic [2:0]           clksel_q;

    ////////////////////
    // Handshake
    ////////////////////

    assign idx = reg_idx(wb_req_i.adr);

    // New access only while no ack is pending
    assign req = wb_req_i.cyc && wb_req_i.stb && !ack_q;
    assign wr_req = req && wb_req_i.we;

    // Single-cycle ack, one wait state
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    // Dropped cycle kills the ack
    assign wb_ack_o = ack_q && wb_req_i.cyc;

    ////////////////////
    // Write decode
    ////////////////////

    // Strobes fire in the request cycle, so blocks update on the ack edge
    assign reg_wr_o.sr_we = wr_req && (idx == REG_INT_SR);
    assign reg_wr_o.mask_we = wr_req && (idx == REG_INT_MASK);
    assign reg_wr_o.led_we = wr_req && (idx == REG_LED);
    assign reg_wr_o.dat = wb_req_i.dat;

    // Clock select, bit 0 value, bit 1 drive enable, bit 2 oscillator
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            clksel_q <= '0;
        end else if (wr_req && (idx == REG_CLKSEL)) begin
            clksel_q <= wb_req_i.dat[2:0];
        end
    end

    assign sst_sel_o = clksel_q[0];
    assign sst_sel_oe_o = clksel_q[1];
    assign local_osc_en_o = clksel_q[2];

    ////////////////////
    // Read mux
    ////////////////////

    // Combinational from the address, sampled by the master on ack
    always_comb begin
        case (idx)
            REG_DEVICE: begin
                wb_dat_o = DEVICE_ID;
            end
            REG_VERSION: begin
                wb_dat_o = VERSION;
            end
            REG_INT_SR: begin
                wb_dat_o = sr_val_i;
            end
            REG_INT_MASK: begin
                wb_dat_o = mask_val_i;
            end
            REG_LED: begin
                wb_dat_o = led_val_i;
            end
            REG_CLKSEL: begin
                wb_dat_o = DATA_W'(clksel_q);
            end
            // Reserved, former SPI and DNA space included
            default: begin
                wb_dat_o = '0;
            end
        endcase
    end

    // Every access gets exactly one ack cycle
    ack_single_cycle: assert property (
        @(posedge clk_i) disable iff (rst_i) wb_ack_o |=> !wb_ack_o
    ) else $error("idctrl_bus: ack held for two cycles");

endmodule

`default_nettype wire

// ==== src/irq_status.sv ====
`timescale 1ns/10ps
`default_nettype none

module irq_status #(
    parameter int IRQ_W = 31
) (
    input  wire                                clk_i,
    input  wire                                rst_i,
    input  wire idctrl_pkg::reg_wr_t           reg_wr_i,
    input  wire [IRQ_W-1:0]                    interrupt_i,
    output logic [idctrl_pkg::DATA_W-1:0]      sr_val_o,
    output logic [idctrl_pkg::DATA_W-1:0]      mask_val_o,
    output logic                               irq_o
);
    import idctrl_pkg::*;

    logic [DATA_W-1:0] live;
    logic [DATA_W-1:0] sr_q;
    logic [DATA_W-1:0] mask_q;
    logic              irq_q;

    // Sources start at bit 1, bit 0 was the flash SPI interrupt
    assign live = DATA_W'({interrupt_i, 1'b0});

    // Status follows the live sources, except in a clearing cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sr_q <= '0;
        end else if (reg_wr_i.sr_we) begin
            // Write one to clear
            sr_q <= sr_q & ~reg_wr_i.dat;
        end else begin
            sr_q <= live;
        end
    end

    // Mask and the combined request
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mask_q <= '0;
            irq_q <= 1'b0;
        end else begin
            if (reg_wr_i.mask_we) begin
                mask_q <= reg_wr_i.dat;
            end
            irq_q <= |(sr_q & ~mask_q);
        end
    end

    assign sr_val_o = sr_q;
    assign mask_val_o = mask_q;
    assign irq_o = irq_q;

    // Fully masked means no request one edge later
    irq_masked_quiet: assert property (
        @(posedge clk_i) disable iff (rst_i) (&mask_q) |=> !irq_o
    ) else $error("irq_status: interrupt raised with all sources masked");

endmodule

`default_nettype wire

// ==== led/led_override.sv ====
`timescale 1ns/10ps
`default_nettype none

module led_override (
    input  wire                                clk_i,
    input  wire                                rst_i,
    input  wire idctrl_pkg::reg_wr_t           reg_wr_i,
    // Activity from the rest of the board
    input  wire [idctrl_pkg::LED_N-1:0]        internal_led_i,
    output logic [idctrl_pkg::DATA_W-1:0]      led_val_o,
    output logic                               fp_led_o
);
    import idctrl_pkg::*;

    logic [DATA_W-1:0] led_q;
    logic [LED_N-1:0]  ovr_wr;
    logic [LED_N-1:0]  ovr_q;
    logic [LED_N-1:0]  merged;

    // Override mask as written
    assign ovr_wr = reg_wr_i.dat[LED_OVR_LSB +: LED_N];
    // Override mask as stored
    assign ovr_q = led_q[LED_OVR_LSB +: LED_N];

    // Written value where overridden, live activity elsewhere
    assign merged = (reg_wr_i.dat[LED_N-1:0] & ovr_wr) | (internal_led_i & ~ovr_wr);

    ////////////////////
    // LED register
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            led_q <= '0;
        end else if (reg_wr_i.led_we) begin
            // Upper bits stored verbatim, FP LED and overrides included
            led_q[DATA_W-1:LED_N] <= reg_wr_i.dat[DATA_W-1:LED_N];
            led_q[LED_N-1:0] <= merged;
        end else begin
            // Sticky capture on LEDs not overridden
            led_q[LED_N-1:0] <= led_q[LED_N-1:0] | (internal_led_i & ~ovr_q);
        end
    end

    assign led_val_o = led_q;

    // Front panel LED drives its pin directly
    assign fp_led_o = led_q[LED_FP_BIT];

endmodule

`default_nettype wire

// ==== led/led_charlieplex.sv ====
`timescale 1ns/10ps
`default_nettype none

module led_charlieplex #(
    parameter int SLOT_CYCLES = 1
) (
    input  wire                                clk_i,
    input  wire                                rst_i,
    input  wire [idctrl_pkg::LED_N-1:0]        led_val_i,
    // Pin level and drive enable, 1 means driven
    output logic [idctrl_pkg::LED_PINS-1:0]    led_pin_o,
    output logic [idctrl_pkg::LED_PINS-1:0]    led_oe_o
);
    import idctrl_pkg::*;

    localparam int PRE_W = (SLOT_CYCLES > 1) ? $clog2(SLOT_CYCLES) : 1;
    localparam int SLOT_W = $clog2(LED_N);
    // Green pairs, then the same pairs red
    localparam int COLOR_N = LED_N / 2;

    // Driven pin pair per green slot, slot 0 at the bottom
    localparam logic [COLOR_N-1:0][LED_PINS-1:0] PAIR_OE = {
        4'b1001,
        4'b1010,
        4'b1100,
        4'b0110,
        4'b0101,
        4'b0011
    };

    // Anode of the green LED in each pair
    localparam logic [COLOR_N-1:0][LED_PINS-1:0] PAIR_ANODE = {
        4'b0001,
        4'b0010,
        4'b0100,
        4'b0010,
        4'b0001,
        4'b0001
    };

    logic [PRE_W-1:0]    pre_q;
    logic                slot_tick;
    logic [SLOT_W-1:0]   slot_q;
    logic                red;
    logic [SLOT_W-1:0]   pair_idx;
    logic [LED_PINS-1:0] pair_oe;
    logic [LED_PINS-1:0] pair_lvl;
    logic [LED_PINS-1:0] pin_q;
    logic [LED_PINS-1:0] oe_q;

    ////////////////////
    // Slot timing
    ////////////////////

    assign slot_tick = (pre_q == PRE_W'(SLOT_CYCLES - 1));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pre_q <= '0;
            slot_q <= '0;
        end else begin
            pre_q <= slot_tick ? '0 : pre_q + 1'b1;
            if (slot_tick) begin
                // Wrap after the last red slot
                slot_q <= (slot_q == SLOT_W'(LED_N - 1)) ? '0 : slot_q + 1'b1;
            end
        end
    end

    ////////////////////
    // Pin pattern
    ////////////////////

    // Red slots reuse the green pair with the levels swapped
    assign red = (slot_q >= SLOT_W'(COLOR_N));
    assign pair_idx = red ? slot_q - SLOT_W'(COLOR_N) : slot_q;
    assign pair_oe = PAIR_OE[pair_idx];
    assign pair_lvl = (PAIR_ANODE[pair_idx] ^ {LED_PINS{red}}) & pair_oe;

    // Registered, pattern trails the slot counter by one cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            oe_q <= '0;
            pin_q <= '0;
        end else if (led_val_i[slot_q]) begin
            oe_q <= pair_oe;
            pin_q <= pair_lvl;
        end else begin
            // LED off, all pins released
            oe_q <= '0;
            pin_q <= '0;
        end
    end

    assign led_pin_o = pin_q;
    assign led_oe_o = oe_q;

    // One pair or nothing, never a third pin fighting the pair
    pin_pair_only: assert property (
        @(posedge clk_i) disable iff (rst_i)
        ($countones(led_oe_o) == 0) || ($countones(led_oe_o) == 2)
    ) else $error("led_charlieplex: %0d pins driven", $countones(led_oe_o));

endmodule

`default_nettype wire

// ==== src/idctrl_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module idctrl_top #(
    parameter logic [idctrl_pkg::DATA_W-1:0] DEVICE_ID = "S5A7",
    parameter logic [idctrl_pkg::DATA_W-1:0] VERSION = 32'h0000_0000,
    parameter int IRQ_W = 31,
    parameter int SLOT_CYCLES = 1
) (
    input  wire                                clk_i,
    input  wire                                rst_i,
    // Wishbone slave
    input  wire idctrl_pkg::wb_req_t           wb_req_i,
    output logic                               wb_ack_o,
    output logic [idctrl_pkg::DATA_W-1:0]      wb_dat_o,
    // Interrupts
    input  wire [IRQ_W-1:0]                    interrupt_i,
    output logic                               irq_o,
    // LEDs
    input  wire [idctrl_pkg::LED_N-1:0]        internal_led_i,
    output logic [idctrl_pkg::LED_PINS-1:0]    led_pin_o,
    output logic [idctrl_pkg::LED_PINS-1:0]    led_oe_o,
    output logic                               fp_led_o,
    // Clock selection
    output logic                               sst_sel_o,
    output logic                               sst_sel_oe_o,
    output logic                               local_osc_en_o
);
    import idctrl_pkg::*;

    reg_wr_t           reg_wr;
    logic [DATA_W-1:0] sr_val;
    logic [DATA_W-1:0] mask_val;
    logic [DATA_W-1:0] led_val;

    // Bus front end, decode and read mux
    idctrl_bus #(
        .DEVICE_ID(DEVICE_ID),
        .VERSION(VERSION)
    ) u_bus (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .wb_req_i(wb_req_i),
        .wb_ack_o(wb_ack_o),
        .wb_dat_o(wb_dat_o),
        .reg_wr_o(reg_wr),
        .sr_val_i(sr_val),
        .mask_val_i(mask_val),
        .led_val_i(led_val),
        .sst_sel_o(sst_sel_o),
        .sst_sel_oe_o(sst_sel_oe_o),
        .local_osc_en_o(local_osc_en_o)
    );

    // Interrupt status and mask
    irq_status #(
        .IRQ_W(IRQ_W)
    ) u_irq (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .reg_wr_i(reg_wr),
        .interrupt_i(interrupt_i),
        .sr_val_o(sr_val),
        .mask_val_o(mask_val),
        .irq_o(irq_o)
    );

    // LED register
    led_override u_led_reg (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .reg_wr_i(reg_wr),
        .internal_led_i(internal_led_i),
        .led_val_o(led_val),
        .fp_led_o(fp_led_o)
    );

    // Only the charlieplexed bits reach the scanner
    led_charlieplex #(
        .SLOT_CYCLES(SLOT_CYCLES)
    ) u_charlie (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .led_val_i(led_val[LED_N-1:0]),
        .led_pin_o(led_pin_o),
        .led_oe_o(led_oe_o)
    );

endmodule

`default_nettype wire

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
    parameter real PERIOD_NS = 10.0,
    parameter int RST_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_o
);

    // Free-running clock
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk_o = ~clk_o;
        end
    end

    // Synchronous reset, released on a rising edge
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== test/tb_idctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_idctrl;
    import idctrl_pkg::*;

    localparam int IRQ_W = 31;
    // "S5A7" in ASCII
    localparam logic [DATA_W-1:0] DEV_ID_EXP = 32'h5335_4137;
    localparam logic [DATA_W-1:0] TB_VERSION = 32'h0001_0203;
    localparam logic [IRQ_W-1:0] IRQ_PAT = 31'h2AC3_5A0F;
    localparam logic [ADDR_W-1:0] LED_ADR = 16'h0018;
    localparam int ACK_TIMEOUT = 20;
    localparam int RST_TIMEOUT = 50;
    // Status plus output register, with margin
    localparam int SETTLE_CYCLES = 3;
    localparam int SCAN_CYCLES = 24;

    // Side outputs compared after an entry
    localparam logic [1:0] SIDE_NONE = 2'd0;
    localparam logic [1:0] SIDE_CLKSEL = 2'd1;
    localparam logic [1:0] SIDE_IRQ = 2'd2;
    localparam logic [1:0] SIDE_FP = 2'd3;

    // One bus access with the inputs held around it
    typedef struct packed {
        logic              wr;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
        logic [IRQ_W-1:0]  irq_in;
        logic [LED_N-1:0]  led_in;
        logic [DATA_W-1:0] rd_exp;
        logic [1:0]        side;
        logic [DATA_W-1:0] side_exp;
    } entry_t;

    logic                clk;
    logic                rst;
    wb_req_t             wb_req;
    logic                wb_ack;
    logic [DATA_W-1:0]   wb_dat;
    logic [IRQ_W-1:0]    interrupt_in;
    logic                irq;
    logic [LED_N-1:0]    internal_led;
    logic [LED_PINS-1:0] led_pin;
    logic [LED_PINS-1:0] led_oe;
    logic                fp_led;
    logic                sst_sel;
    logic                sst_sel_oe;
    logic                local_osc_en;

    entry_t              entries[$];
    string               names[$];
    integer              seed;
    int                  errors;
    int                  checks;
    int                  waited;
    logic [DATA_W-1:0]   rnd;
    logic [DATA_W-1:0]   rdata;
    bit                  acked;

    tb_clk_gen #(
        .PERIOD_NS(10.0),
        .RST_CYCLES(8)
    ) u_clk_gen (
        .clk_o(clk),
        .rst_o(rst)
    );

    idctrl_top #(
        .VERSION(TB_VERSION),
        .IRQ_W(IRQ_W),
        .SLOT_CYCLES(1)
    ) uut (
        .clk_i(clk),
        .rst_i(rst),
        .wb_req_i(wb_req),
        .wb_ack_o(wb_ack),
        .wb_dat_o(wb_dat),
        .interrupt_i(interrupt_in),
        .irq_o(irq),
        .internal_led_i(internal_led),
        .led_pin_o(led_pin),
        .led_oe_o(led_oe),
        .fp_led_o(fp_led),
        .sst_sel_o(sst_sel),
        .sst_sel_oe_o(sst_sel_oe),
        .local_osc_en_o(local_osc_en)
    );

    ////////////////////
    // Helpers
    ////////////////////

    task automatic check_value(input string name, input logic [DATA_W-1:0] exp_val,
                               input logic [DATA_W-1:0] act_val);
        checks++;
        if (act_val !== exp_val) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp_val, act_val);
        end
    endtask

    task automatic add_entry(input string name, input logic wr, input logic [ADDR_W-1:0] adr,
                             input logic [DATA_W-1:0] dat, input logic [IRQ_W-1:0] irq_in,
                             input logic [LED_N-1:0] led_in, input logic [DATA_W-1:0] rd_exp,
                             input logic [1:0] side, input logic [DATA_W-1:0] side_exp);
        entry_t e;
        e.wr = wr;
        e.adr = adr;
        e.dat = dat;
        e.irq_in = irq_in;
        e.led_in = led_in;
        e.rd_exp = rd_exp;
        e.side = side;
        e.side_exp = side_exp;
        entries.push_back(e);
        names.push_back(name);
    endtask

    // Single access, request on a rising edge, ack sampled on falling edges
    task automatic bus_access(input string name, input logic wr, input logic [ADDR_W-1:0] adr,
                              input logic [DATA_W-1:0] dat, output logic [DATA_W-1:0] rd,
                              output bit ok);
        wb_req_t req;
        int      n;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we = wr;
        req.adr = adr;
        req.dat = dat;
        ok = 1'b0;
        rd = '0;
        n = 0;
        @(posedge clk);
        wb_req <= req;
        while (!ok && n < ACK_TIMEOUT) begin
            @(negedge clk);
            if (wb_ack === 1'b1) begin
                ok = 1'b1;
                rd = wb_dat;
            end
            n++;
        end
        if (!ok) begin
            errors++;
            $display("Test %s got no ack within %0d cycles", name, ACK_TIMEOUT);
        end
        @(posedge clk);
        wb_req <= '0;
    endtask

    function automatic logic [DATA_W-1:0] side_value(input logic [1:0] side);
        case (side)
            SIDE_CLKSEL: return {29'b0, local_osc_en, sst_sel_oe, sst_sel};
            SIDE_IRQ: return {31'b0, irq};
            SIDE_FP: return {31'b0, fp_led};
            default: return '0;
        endcase
    endfunction

    task automatic apply_entry(input int i);
        entry_t            e;
        logic [DATA_W-1:0] rd;
        bit                ok;
        e = entries[i];
        @(posedge clk);
        interrupt_in <= e.irq_in;
        internal_led <= e.led_in;
        repeat (SETTLE_CYCLES) @(posedge clk);
        bus_access(names[i], e.wr, e.adr, e.dat, rd, ok);
        // Writes show the freshly written register during their ack
        if (ok) begin
            check_value(names[i], e.rd_exp, rd);
        end
        if (e.side != SIDE_NONE) begin
            @(negedge clk);
            check_value({names[i], "_pins"}, e.side_exp, side_value(e.side));
        end
    endtask

    // Green LED of each pin pair, anode pin
    function automatic int anode_pin(input int pair);
        case (pair)
            0, 1, 5: return 0;
            2, 4: return 1;
            default: return 2;
        endcase
    endfunction

    // Same pairs, cathode pin
    function automatic int cathode_pin(input int pair);
        case (pair)
            0: return 1;
            1, 2: return 2;
            default: return 3;
        endcase
    endfunction

    // Watch the LED pins over two full scans
    task automatic scan_watch(input int k, input bit lit);
        logic [LED_PINS-1:0] exp_oe;
        logic [LED_PINS-1:0] exp_pin;
        int                  hits;
        string               name;
        exp_oe = (4'b1 << anode_pin(k % 6)) | (4'b1 << cathode_pin(k % 6));
        // Red half drives the pair the other way round
        exp_pin = (k < 6) ? (4'b1 << anode_pin(k % 6)) : (4'b1 << cathode_pin(k % 6));
        hits = 0;
        name = lit ? $sformatf("scan_led_%0d", k) : "scan_all_off";
        for (int c = 0; c < SCAN_CYCLES; c++) begin
            @(negedge clk);
            if (!lit) begin
                check_value(name, '0, DATA_W'(led_oe));
            end else if (led_oe !== 4'b0) begin
                check_value({name, "_oe"}, DATA_W'(exp_oe), DATA_W'(led_oe));
                if (led_oe === exp_oe) begin
                    hits++;
                    check_value({name, "_level"}, DATA_W'(exp_pin), DATA_W'(led_pin));
                end
            end
        end
        if (lit && hits == 0) begin
            errors++;
            $display("LED %0d was never driven during the scan", k);
        end
    endtask

    ////////////////////
    // Stimulus table
    ////////////////////

    task automatic build_table();
        add_entry("device_id", 0, 16'h0000, '0, '0, '0, DEV_ID_EXP, SIDE_NONE, '0);
        add_entry("version", 0, 16'h0004, '0, '0, '0, TB_VERSION, SIDE_NONE, '0);
        // Unused and former SPI/DNA indices
        add_entry("reserved_28", 0, 16'h0028, '0, '0, '0, '0, SIDE_NONE, '0);
        add_entry("reserved_10", 0, 16'h0010, '0, '0, '0, '0, SIDE_NONE, '0);
        for (int r = 0; r < 2; r++) begin
            rnd = $random(seed);
            add_entry("clksel_wr", 1, 16'h001C, rnd, '0, '0, {29'b0, rnd[2:0]},
                      SIDE_NONE, '0);
            add_entry("clksel_rd", 0, 16'h001C, '0, '0, '0, {29'b0, rnd[2:0]},
                      SIDE_CLKSEL, {29'b0, rnd[2:0]});
        end
        // Sources land one bit up
        add_entry("irq_status", 0, 16'h0008, '0, IRQ_PAT, '0, {IRQ_PAT, 1'b0}, SIDE_IRQ, 1);
        add_entry("mask_wr", 1, 16'h000C, '1, IRQ_PAT, '0, '1, SIDE_NONE, '0);
        add_entry("mask_rd", 0, 16'h000C, '0, IRQ_PAT, '0, '1, SIDE_IRQ, 0);
        // Clearing cycle reads zero while the sources are still high
        add_entry("sr_clear_live", 1, 16'h0008, '1, IRQ_PAT, '0, '0, SIDE_NONE, '0);
        add_entry("sr_clear", 1, 16'h0008, '1, '0, '0, '0, SIDE_NONE, '0);
        add_entry("sr_after_clear", 0, 16'h0008, '0, '0, '0, '0, SIDE_IRQ, 0);
        add_entry("mask_release", 1, 16'h000C, '0, '0, '0, '0, SIDE_NONE, '0);
        add_entry("irq_quiet", 0, 16'h000C, '0, '0, '0, '0, SIDE_IRQ, 0);
        // Override LEDs 0..5 to 0x2A, others follow activity 0xC40
        add_entry("led_ovr_wr", 1, LED_ADR, 32'h003F_13EA, '0, 12'hC45, 32'h003F_1C6A,
                  SIDE_NONE, '0);
        add_entry("led_ovr_rd", 0, LED_ADR, '0, '0, 12'hC45, 32'h003F_1C6A, SIDE_FP, 1);
        // Bit 0 overridden, so only 7 and 8 stick
        add_entry("led_pulse", 0, LED_ADR, '0, '0, 12'h181, 32'h003F_1DEA, SIDE_FP, 1);
        add_entry("led_sticky", 0, LED_ADR, '0, '0, 12'h000, 32'h003F_1DEA, SIDE_FP, 1);
        add_entry("led_clear_wr", 1, LED_ADR, '0, '0, '0, '0, SIDE_NONE, '0);
        add_entry("led_clear_rd", 0, LED_ADR, '0, '0, '0, '0, SIDE_FP, 0);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        wb_req = '0;
        interrupt_in = '0;
        internal_led = '0;
        seed = 32'h8c218401;
        errors = 0;
        checks = 0;
        build_table();

        waited = 0;
        while (rst !== 1'b0 && waited < RST_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (rst !== 1'b0) begin
            errors++;
            $display("Reset was never released");
        end

        // Everything quiet out of reset
        @(negedge clk);
        check_value("reset_state", '0,
                    {23'b0, wb_ack, irq, led_oe, sst_sel_oe, local_osc_en, fp_led});

        for (int i = 0; i < entries.size(); i++) begin
            apply_entry(i);
        end

        // One LED at a time, all bits overridden
        for (int k = 0; k < LED_N; k++) begin
            bus_access("scan_led_wr", 1'b1, LED_ADR, 32'h0FFF_0000 | (32'd1 << k), rdata, acked);
            repeat (2) @(posedge clk);
            scan_watch(k, 1'b1);
        end
        bus_access("scan_off_wr", 1'b1, LED_ADR, 32'h0FFF_0000, rdata, acked);
        repeat (2) @(posedge clk);
        scan_watch(0, 1'b0);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== surf_idctrl.f ====
common/idctrl_pkg.sv
src/idctrl_bus.sv
src/irq_status.sv
led/led_override.sv
led/led_charlieplex.sv
src/idctrl_top.sv
test/tb_clk_gen.sv
test/tb_idctrl.sv

// ==== Bender.yml ====
package:
  name: surf_idctrl

sources:
  - files:
      - common/idctrl_pkg.sv
      - src/idctrl_bus.sv
      - src/irq_status.sv
      - led/led_override.sv
      - led/led_charlieplex.sv
      - src/idctrl_top.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_idctrl.sv
